// ==== verilog/beamform_settings.svh ====
/* widths, counts and shifts of the four-channel beamforming combiner
   included by the package and by every module that sizes logic from these values */
`ifndef BEAMFORM_SETTINGS_SVH
`define BEAMFORM_SETTINGS_SVH

// one signed sample and one signed weight part
`define BF_SAMPLE_W   16
`define BF_WEIGHT_W   8

// samples per channel in a beat, and antenna channels per beat
`define BF_LANES      8
`define BF_CHANNELS   4

// weights are fractions with this many bits after the binary point
`define BF_FRAC_SHIFT 7
// averaging shift after summing the channels, log2 of BF_CHANNELS
`define BF_SUM_SHIFT  2

// default number of weighted beats held between weighting and combining
`define BF_FIFO_DEPTH 4

`endif

// ==== verilog/beamform_pkg.sv ====
/* vector types of the beamforming combiner, shared by the RTL and the testbench
   channel c, lane l of a chan_vec_t sits at bits (c*BF_LANES + l)*BF_SAMPLE_W upward */
`default_nettype none

package beamform_pkg;

`include "beamform_settings.svh"

    // one signed sample of a real or imaginary part
    typedef logic signed [`BF_SAMPLE_W-1:0] sample_t;
    // one signed weight part, value/128 is the applied gain
    typedef logic signed [`BF_WEIGHT_W-1:0] weight_t;
    // full-precision product of a sample and a weight part
    typedef logic signed [`BF_SAMPLE_W+`BF_WEIGHT_W-1:0] product_t;
    // sum of one lane over all channels, two guard bits for four channels
    typedef logic signed [`BF_SAMPLE_W+1:0] acc_t;

    // the lanes of one channel's real or imaginary part
    typedef logic [`BF_LANES*`BF_SAMPLE_W-1:0] lane_vec_t;
    // one part of every channel, channel 0 in the low bits
    typedef logic [`BF_CHANNELS*`BF_LANES*`BF_SAMPLE_W-1:0] chan_vec_t;
    // one weight part per channel, channel 0 in the low byte
    typedef logic [`BF_CHANNELS*`BF_WEIGHT_W-1:0] weight_vec_t;

endpackage

`default_nettype wire

// ==== verilog/beam_beat_if.sv ====
/* valid/ready link carrying one weighted beat of all channels between the internal blocks
   the source drives the beat, the sink drives ready, monitor only observes */
`timescale 1ns/1ps
`default_nettype none

interface beam_beat_if;

    // a beat moves on an edge where valid and ready are both high
    logic valid;
    logic ready;
    logic last;

    // beats the source has accepted but not yet presented, used by the sink's room test
    logic [1:0] in_flight;

    // real and imaginary parts of every channel and lane
    beamform_pkg::chan_vec_t re;
    beamform_pkg::chan_vec_t im;

    modport source (
        output valid, last, re, im, in_flight,
        input  ready
    );

    modport sink (
        input  valid, last, re, im, in_flight,
        output ready
    );

    modport monitor (
        input valid, ready, last, re, im, in_flight
    );

endinterface

`default_nettype wire

// ==== verilog/channel_weighter.sv ====
/* producer of the beamformer: multiplies every sample by its channel's complex Q7 weight
   two register stages without stall, so each accept gives one wt valid two cycles later */
`timescale 1ns/1ps
`default_nettype none
`include "beamform_settings.svh"

module channel_weighter (
    input  wire                             clock,
    input  wire                             resetn,
    input  wire                             in_valid,
    output logic                            in_ready,
    input  wire                             in_last,
    input  wire beamform_pkg::chan_vec_t    in_re,
    input  wire beamform_pkg::chan_vec_t    in_im,
    input  wire beamform_pkg::weight_vec_t  weight_re,
    input  wire beamform_pkg::weight_vec_t  weight_im,
    beam_beat_if.source                     wt
);

    // stage 1 partial products, indexed [channel][lane]
    // rr is re*wr, ii is im*wi, ri is re*wi, ir is im*wr
    beamform_pkg::product_t p_rr [`BF_CHANNELS][`BF_LANES];
    beamform_pkg::product_t p_ii [`BF_CHANNELS][`BF_LANES];
    beamform_pkg::product_t p_ri [`BF_CHANNELS][`BF_LANES];
    beamform_pkg::product_t p_ir [`BF_CHANNELS][`BF_LANES];
    logic                   s1_valid;
    logic                   s1_last;

    // stage 2 holds the finished beat that is presented on wt
    logic                    s2_valid;
    logic                    s2_last;
    beamform_pkg::chan_vec_t s2_re;
    beamform_pkg::chan_vec_t s2_im;

    logic accept;

    // pick lane l of channel c out of a packed channel vector
    function automatic beamform_pkg::sample_t lane_of(input beamform_pkg::chan_vec_t v,
                                                      input int c, input int l);
        return v[(c * `BF_LANES + l) * `BF_SAMPLE_W +: `BF_SAMPLE_W];
    endfunction

    // signed product at full width, both operands sign-extended first
    function automatic beamform_pkg::product_t mul(input beamform_pkg::sample_t s,
                                                   input beamform_pkg::weight_t w);
        return beamform_pkg::product_t'(s) * beamform_pkg::product_t'(w);
    endfunction

    // combines two products with one guard bit, drops the weight's fraction bits
    // and wraps the result to a sample
    function automatic beamform_pkg::sample_t rescale(input beamform_pkg::product_t a,
                                                      input beamform_pkg::product_t b,
                                                      input logic subtract);
        logic signed [`BF_SAMPLE_W+`BF_WEIGHT_W:0] t;
        if (subtract) begin
            t = $signed({a[$bits(a)-1], a}) - $signed({b[$bits(b)-1], b});
        end else begin
            t = $signed({a[$bits(a)-1], a}) + $signed({b[$bits(b)-1], b});
        end
        return beamform_pkg::sample_t'(t >>> `BF_FRAC_SHIFT);
    endfunction

    // the buffer's room test already covers both stages, so its ready is ours
    assign in_ready = wt.ready;
    assign accept = in_valid && wt.ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
        end
    end

    // weights are sampled together with the beat on the accept edge
    always_ff @(posedge clock) begin
        s1_last <= in_last;
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            for (int l = 0; l < `BF_LANES; l++) begin
                p_rr[c][l] <= mul(lane_of(in_re, c, l), weight_re[c*`BF_WEIGHT_W +: `BF_WEIGHT_W]);
                p_ii[c][l] <= mul(lane_of(in_im, c, l), weight_im[c*`BF_WEIGHT_W +: `BF_WEIGHT_W]);
                p_ri[c][l] <= mul(lane_of(in_re, c, l), weight_im[c*`BF_WEIGHT_W +: `BF_WEIGHT_W]);
                p_ir[c][l] <= mul(lane_of(in_im, c, l), weight_re[c*`BF_WEIGHT_W +: `BF_WEIGHT_W]);
            end
        end
    end

    // real part is rr - ii, imaginary part is ri + ir
    always_ff @(posedge clock) begin
        s2_last <= s1_last;
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            for (int l = 0; l < `BF_LANES; l++) begin
                s2_re[(c*`BF_LANES + l)*`BF_SAMPLE_W +: `BF_SAMPLE_W] <=
                    rescale(p_rr[c][l], p_ii[c][l], 1'b1);
                s2_im[(c*`BF_LANES + l)*`BF_SAMPLE_W +: `BF_SAMPLE_W] <=
                    rescale(p_ri[c][l], p_ir[c][l], 1'b0);
            end
        end
    end

    assign wt.valid = s2_valid;
    assign wt.last  = s2_last;
    assign wt.re    = s2_re;
    assign wt.im    = s2_im;
    // beats accepted but not yet written into the buffer
    assign wt.in_flight = {1'b0, s1_valid} + {1'b0, s2_valid};

endmodule

`default_nettype wire

// ==== verilog/beat_fifo.sv ====
/* circular buffer of weighted beats between the producer and the combiner
   the producer never stalls, so room is reserved for its in-flight beats before each accept */
`timescale 1ns/1ps
`default_nettype none
`include "beamform_settings.svh"

module beat_fifo #(
    parameter int DEPTH = `BF_FIFO_DEPTH
) (
    input  wire         clock,
    input  wire         resetn,
    beam_beat_if.sink   wt,
    beam_beat_if.source cb
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // beat storage, the head is read straight out of it
    beamform_pkg::chan_vec_t mem_re   [DEPTH];
    beamform_pkg::chan_vec_t mem_im   [DEPTH];
    logic                    mem_last [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // stored beats plus those still in the producer
    logic [CNT_W:0]   committed;
    logic             started;
    logic             wr_en;
    logic             rd_en;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign committed = {1'b0, count} + (CNT_W+1)'(wt.in_flight);

    // ready comes up one cycle after reset is released, then follows the room test
    assign wt.ready = started && (committed < (CNT_W+1)'(DEPTH));

    // every producer valid is written, its slot was reserved at accept time
    assign wr_en = wt.valid;
    assign rd_en = cb.valid && cb.ready;

    assign cb.valid = (count != '0);
    assign cb.re    = mem_re[rd_ptr];
    assign cb.im    = mem_im[rd_ptr];
    assign cb.last  = mem_last[rd_ptr];
    // the head is presented combinationally, nothing is in flight toward the combiner
    assign cb.in_flight = 2'd0;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            started <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            started <= 1'b1;
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem_re[wr_ptr]   <= wt.re;
            mem_im[wr_ptr]   <= wt.im;
            mem_last[wr_ptr] <= wt.last;
        end
    end

    // the producer's in-flight count has to keep its writes off a full buffer
    a_no_write_when_full: assert property (@(posedge clock) disable iff (!resetn)
        wt.valid |-> (count < CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// ==== verilog/channel_combiner.sv ====
/* consumer of the beamformer: averages the four weighted channels lane by lane
   one output register, loaded when empty or when its beat is taken on the same edge */
`timescale 1ns/1ps
`default_nettype none
`include "beamform_settings.svh"

module channel_combiner (
    input  wire                       clock,
    input  wire                       resetn,
    beam_beat_if.sink                 cb,
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic                      out_last,
    output beamform_pkg::lane_vec_t   out_re,
    output beamform_pkg::lane_vec_t   out_im
);

    // channel average of the head beat, ready to be registered
    beamform_pkg::lane_vec_t avg_re;
    beamform_pkg::lane_vec_t avg_im;
    logic                    load;

    // the register can take a new beat if it is empty or being emptied now
    assign cb.ready = !out_valid || out_ready;
    assign load = cb.valid && cb.ready;

    // each lane sums at 18 bits, the shift by 2 then always fits a sample again
    always_comb begin
        beamform_pkg::acc_t acc_re;
        beamform_pkg::acc_t acc_im;
        avg_re = '0;
        avg_im = '0;
        for (int l = 0; l < `BF_LANES; l++) begin
            acc_re = '0;
            acc_im = '0;
            for (int c = 0; c < `BF_CHANNELS; c++) begin
                acc_re = acc_re + beamform_pkg::acc_t'(beamform_pkg::sample_t'(
                    cb.re[(c*`BF_LANES + l)*`BF_SAMPLE_W +: `BF_SAMPLE_W]));
                acc_im = acc_im + beamform_pkg::acc_t'(beamform_pkg::sample_t'(
                    cb.im[(c*`BF_LANES + l)*`BF_SAMPLE_W +: `BF_SAMPLE_W]));
            end
            avg_re[l*`BF_SAMPLE_W +: `BF_SAMPLE_W] =
                beamform_pkg::sample_t'(acc_re >>> `BF_SUM_SHIFT);
            avg_im[l*`BF_SAMPLE_W +: `BF_SAMPLE_W] =
                beamform_pkg::sample_t'(acc_im >>> `BF_SUM_SHIFT);
        end
    end

    // while out_ready is low nothing here changes, so the sink sees a steady beat
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (cb.ready) begin
            out_valid <= cb.valid;
            out_last  <= cb.valid && cb.last;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_re <= avg_re;
            out_im <= avg_im;
        end
    end

    // a beat that is offered and not taken stays valid and unchanged
    a_hold_on_stall: assert property (@(posedge clock) disable iff (!resetn)
        (out_valid && !out_ready) |=> (out_valid && $stable({out_re, out_im, out_last})));

endmodule

`default_nettype wire

// ==== verilog/beamform_top.sv ====
/* top of the four-channel complex beamforming combiner
   weighting feeds a small buffer, the buffer feeds the channel average; plain valid/ready ports */
`timescale 1ns/1ps
`default_nettype none
`include "beamform_settings.svh"

module beamform_top (
    input  wire                             clock,
    input  wire                             resetn,
    // input beats, the weights are taken with the beat
    input  wire                             in_valid,
    output logic                            in_ready,
    input  wire                             in_last,
    input  wire beamform_pkg::chan_vec_t    in_re,
    input  wire beamform_pkg::chan_vec_t    in_im,
    input  wire beamform_pkg::weight_vec_t  weight_re,
    input  wire beamform_pkg::weight_vec_t  weight_im,
    // combined output beats
    output logic                            out_valid,
    input  wire                             out_ready,
    output logic                            out_last,
    output beamform_pkg::lane_vec_t         out_re,
    output beamform_pkg::lane_vec_t         out_im
);

    // weighter to buffer, and buffer to combiner
    beam_beat_if wt_if ();
    beam_beat_if cb_if ();

    channel_weighter i_weighter (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .in_re     (in_re),
        .in_im     (in_im),
        .weight_re (weight_re),
        .weight_im (weight_im),
        .wt        (wt_if.source)
    );

    beat_fifo #(
        .DEPTH (`BF_FIFO_DEPTH)
    ) i_fifo (
        .clock  (clock),
        .resetn (resetn),
        .wt     (wt_if.sink),
        .cb     (cb_if.source)
    );

    channel_combiner i_combiner (
        .clock     (clock),
        .resetn    (resetn),
        .cb        (cb_if.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_re    (out_re),
        .out_im    (out_im)
    );

endmodule

`default_nettype wire

// ==== verif/tb_beamform.sv ====
/* testbench of the beamforming combiner: random and extreme beats through beamform_top
   expected beats come from a reference model and are compared in accept order */
`timescale 1ns/1ps
`default_nettype none
`include "beamform_settings.svh"

module tb_beamform;

    localparam int RESET_CYCLES  = 16;
    localparam int UNIT_BEATS    = 40;
    localparam int RAND_BEATS    = 60;
    localparam int STALL_BEATS   = 80;
    localparam int EXTREME_BEATS = 8;
    localparam int TOTAL_BEATS   = UNIT_BEATS + RAND_BEATS + STALL_BEATS + EXTREME_BEATS;
    // a half-rate sink costs about two cycles a beat, plus a few pipeline drains
    localparam int STIM_CYCLES    = RESET_CYCLES + 2 * TOTAL_BEATS + 64;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    logic                      clock;
    logic                      resetn;
    logic                      in_valid;
    logic                      in_ready;
    logic                      in_last;
    beamform_pkg::chan_vec_t   in_re;
    beamform_pkg::chan_vec_t   in_im;
    beamform_pkg::weight_vec_t weight_re;
    beamform_pkg::weight_vec_t weight_im;
    logic                      out_valid;
    logic                      out_ready;
    logic                      out_last;
    beamform_pkg::lane_vec_t   out_re;
    beamform_pkg::lane_vec_t   out_im;

    integer seed = 29180;
    // expected beats as {last, re lanes, im lanes}, oldest first
    logic [2*`BF_LANES*`BF_SAMPLE_W:0] exp_q [$];
    int   mismatch_errors = 0;
    int   other_errors = 0;
    int   accepted = 0;
    int   received = 0;
    int   cycles = 0;
    logic stall_mode = 1'b0;
    logic saw_in_ready_low = 1'b0;

    beamform_top i_dut (
        .clock     (clock),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .in_re     (in_re),
        .in_im     (in_im),
        .weight_re (weight_re),
        .weight_im (weight_im),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_re    (out_re),
        .out_im    (out_im)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // weight each sample by its Q7 complex weight, wrap to 16 bits, then average the channels
    function automatic logic [2*`BF_LANES*`BF_SAMPLE_W-1:0] ref_combine(
        input beamform_pkg::chan_vec_t re, input beamform_pkg::chan_vec_t im,
        input beamform_pkg::weight_vec_t wr, input beamform_pkg::weight_vec_t wi);
        int sr;
        int si;
        int cr;
        int ci;
        int prod_re;
        int prod_im;
        int sum_re;
        int sum_im;
        beamform_pkg::lane_vec_t o_re;
        beamform_pkg::lane_vec_t o_im;
        for (int l = 0; l < `BF_LANES; l++) begin
            sum_re = 0;
            sum_im = 0;
            for (int c = 0; c < `BF_CHANNELS; c++) begin
                sr = int'(beamform_pkg::sample_t'(
                    re[(c*`BF_LANES + l)*`BF_SAMPLE_W +: `BF_SAMPLE_W]));
                si = int'(beamform_pkg::sample_t'(
                    im[(c*`BF_LANES + l)*`BF_SAMPLE_W +: `BF_SAMPLE_W]));
                cr = int'(beamform_pkg::weight_t'(wr[c*`BF_WEIGHT_W +: `BF_WEIGHT_W]));
                ci = int'(beamform_pkg::weight_t'(wi[c*`BF_WEIGHT_W +: `BF_WEIGHT_W]));
                prod_re = (sr * cr - si * ci) >>> `BF_FRAC_SHIFT;
                prod_im = (sr * ci + si * cr) >>> `BF_FRAC_SHIFT;
                // each weighted sample wraps to a sample before the sum
                sum_re += int'(beamform_pkg::sample_t'(prod_re));
                sum_im += int'(beamform_pkg::sample_t'(prod_im));
            end
            o_re[l*`BF_SAMPLE_W +: `BF_SAMPLE_W] =
                beamform_pkg::sample_t'(sum_re >>> `BF_SUM_SHIFT);
            o_im[l*`BF_SAMPLE_W +: `BF_SAMPLE_W] =
                beamform_pkg::sample_t'(sum_im >>> `BF_SUM_SHIFT);
        end
        return {o_re, o_im};
    endfunction

    function automatic beamform_pkg::chan_vec_t rand_chan();
        beamform_pkg::chan_vec_t v;
        for (int i = 0; i < $bits(v) / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    // full range of weights, negative values included
    function automatic beamform_pkg::weight_vec_t rand_weights();
        return $random(seed);
    endfunction

    // lanes alternate between the largest and the most negative sample
    function automatic beamform_pkg::chan_vec_t extreme_vec(input logic flip);
        beamform_pkg::chan_vec_t v;
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            for (int l = 0; l < `BF_LANES; l++) begin
                v[(c*`BF_LANES + l)*`BF_SAMPLE_W +: `BF_SAMPLE_W] =
                    ((((c + l) % 2) != 0) ^ flip) ? 16'h8000 : 16'h7fff;
            end
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic compare_lanes(input string tag,
                                 input beamform_pkg::lane_vec_t got_re,
                                 input beamform_pkg::lane_vec_t got_im,
                                 input beamform_pkg::lane_vec_t want_re,
                                 input beamform_pkg::lane_vec_t want_im);
        for (int l = 0; l < `BF_LANES; l++) begin
            check_value($sformatf("%s out_re lane %0d", tag, l),
                        got_re[l*`BF_SAMPLE_W +: `BF_SAMPLE_W],
                        want_re[l*`BF_SAMPLE_W +: `BF_SAMPLE_W]);
            check_value($sformatf("%s out_im lane %0d", tag, l),
                        got_im[l*`BF_SAMPLE_W +: `BF_SAMPLE_W],
                        want_im[l*`BF_SAMPLE_W +: `BF_SAMPLE_W]);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the accept
    task automatic send_beat(input beamform_pkg::chan_vec_t re, input beamform_pkg::chan_vec_t im,
                             input beamform_pkg::weight_vec_t wr,
                             input beamform_pkg::weight_vec_t wi, input logic last);
        in_valid  = 1'b1;
        in_last   = last;
        in_re     = re;
        in_im     = im;
        weight_re = wr;
        weight_im = wi;
        while (!in_ready) @(negedge clock);
        @(negedge clock);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clock);
        repeat (4) @(negedge clock);
    endtask

    // the next sink state is drawn on the rising edge, away from the stimulus draws
    task automatic drive_out_ready();
        logic next_ready;
        forever begin
            @(posedge clock);
            next_ready = stall_mode ? ($random(seed) % 2 == 0) : 1'b1;
            @(negedge clock);
            out_ready = next_ready;
        end
    endtask

    // every accepted beat queues its expected output
    task automatic record_accepts();
        forever begin
            @(posedge clock);
            if (resetn && in_valid && in_ready) begin
                exp_q.push_back({in_last, ref_combine(in_re, in_im, weight_re, weight_im)});
                accepted++;
            end
            if (stall_mode && in_valid && !in_ready) begin
                saw_in_ready_low = 1'b1;
            end
        end
    endtask

    task automatic compare_outputs();
        logic [2*`BF_LANES*`BF_SAMPLE_W:0] want;
        logic                              hold_pending;
        beamform_pkg::lane_vec_t           held_re;
        beamform_pkg::lane_vec_t           held_im;
        logic                              held_last;
        hold_pending = 1'b0;
        forever begin
            @(posedge clock);
            if (resetn) begin
                // a beat offered and not taken must come back unchanged
                if (hold_pending) begin
                    check_value("held out_valid", {15'd0, out_valid}, 16'd1);
                    check_value("held out_last", {15'd0, out_last}, {15'd0, held_last});
                    compare_lanes("held", out_re, out_im, held_re, held_im);
                end
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        other_errors++;
                        $display("an output beat at %0t has no accepted input beat left", $time);
                    end else begin
                        want = exp_q.pop_front();
                        check_value("out_last", {15'd0, out_last},
                                    {15'd0, want[2*`BF_LANES*`BF_SAMPLE_W]});
                        compare_lanes("beat", out_re, out_im,
                                      want[2*`BF_LANES*`BF_SAMPLE_W-1:`BF_LANES*`BF_SAMPLE_W],
                                      want[`BF_LANES*`BF_SAMPLE_W-1:0]);
                        received++;
                    end
                end
                hold_pending = out_valid && !out_ready;
                held_re      = out_re;
                held_im      = out_im;
                held_last    = out_last;
            end
        end
    endtask

    task automatic report_result();
        $display("errors: %0d mismatches, %0d other, %0d beats accepted, %0d received",
                 mismatch_errors, other_errors, accepted, received);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
    endtask

    task automatic watch_timeout();
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        other_errors++;
        $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_result();
        $finish;
    endtask

    initial begin
        resetn    = 1'b0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_re     = '0;
        in_im     = '0;
        weight_re = '0;
        weight_im = '0;
        out_ready = 1'b1;
        fork
            drive_out_ready();
            record_accepts();
            compare_outputs();
            watch_timeout();
        join_none
        repeat (RESET_CYCLES) @(negedge clock);
        resetn = 1'b1;
        check_value("out_valid after reset", {15'd0, out_valid}, 16'd0);
        check_value("out_last after reset", {15'd0, out_last}, 16'd0);
        @(negedge clock);
        check_value("in_ready after reset", {15'd0, in_ready}, 16'd1);

        // weight 127/128 on every channel, no imaginary part
        for (int i = 0; i < UNIT_BEATS; i++) begin
            send_beat(rand_chan(), rand_chan(), {4{8'sd127}}, '0, (i % 8) == 7);
        end
        // random complex weights and random frame ends
        for (int i = 0; i < RAND_BEATS; i++) begin
            send_beat(rand_chan(), rand_chan(), rand_weights(), rand_weights(),
                      $random(seed) % 4 == 0);
        end
        wait_drain();

        // half-rate sink, the buffer fills and in_ready has to drop
        stall_mode = 1'b1;
        for (int i = 0; i < STALL_BEATS; i++) begin
            send_beat(rand_chan(), rand_chan(), rand_weights(), rand_weights(),
                      $random(seed) % 4 == 0);
        end
        wait_drain();
        stall_mode = 1'b0;
        if (!saw_in_ready_low) begin
            other_errors++;
            $display("in_ready never fell while the output was stalled");
        end

        // extreme samples with the largest weights of both signs
        for (int k = 0; k < EXTREME_BEATS; k++) begin
            send_beat(extreme_vec(k[0]), extreme_vec(k[1]),
                      k[2] ? {4{8'h80}} : {4{8'h7f}},
                      k[0] ? {2{8'h7f, 8'h80}} : {2{8'h80, 8'h7f}}, k == EXTREME_BEATS - 1);
        end
        wait_drain();

        // with every expected beat delivered the DUT is idle and has room again
        check_value("out_valid at end", {15'd0, out_valid}, 16'd0);
        check_value("in_ready at end", {15'd0, in_ready}, 16'd1);
        report_result();
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/beamform_pkg.sv
verilog/beam_beat_if.sv
verilog/channel_weighter.sv
verilog/beat_fifo.sv
verilog/channel_combiner.sv
verilog/beamform_top.sv
verif/tb_beamform.sv

// ==== Makefile ====
# Verilator simulation of the four-channel beamforming combiner

.PHONY: all run clean

all: run

# rebuilt only when the file list or one of the sources changes
obj_dir/Vtb_beamform: vlog.f verilog/beamform_settings.svh $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -f vlog.f --top-module tb_beamform

# the log decides, the simulator's exit status alone does not
run: obj_dir/Vtb_beamform
	./obj_dir/Vtb_beamform > sim.log 2>&1 || true
	cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
